// ==== clock/time_of_day.sv ====
module time_of_day (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 sec_tick,
	output light_show_pkg::tod_t tod
);

	import light_show_pkg::*;

	logic sec_wrap;
	logic min_wrap;
	logic hour_wrap;

	// carry chain, evaluated on the current time
	assign sec_wrap  = (tod.second == 6'd59);
	assign min_wrap  = (tod.minute == 6'd59);
	assign hour_wrap = (tod.hour == 5'd23);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tod.hour   <= START_HOUR;
			tod.minute <= START_MINUTE;
			tod.second <= '0;
		end else if (sec_tick) begin
			if (sec_wrap) begin
				tod.second <= '0;
				if (min_wrap) begin
					tod.minute <= '0;
					if (hour_wrap) begin
						tod.hour <= '0; // midnight
					end else begin
						tod.hour <= tod.hour + 1'b1;
					end
				end else begin
					tod.minute <= tod.minute + 1'b1;
				end
			end else begin
				tod.second <= tod.second + 1'b1;
			end
		end
	end

	// the time never leaves a valid wall clock value
	a_tod_range: assert property (@(posedge clk) disable iff (!rst_n)
		(tod.minute < 6'd60) && (tod.second < 6'd60) && (tod.hour < 5'd24));

endmodule

// ==== common/light_show_pkg.sv ====
package light_show_pkg;

	//////////////////////////////
	// channel and calendar constants
	//////////////////////////////

	localparam int NUM_LIGHTS = 8;

	localparam logic [4:0] HOUR_ON  = 5'd16; // 4pm, lights may start
	localparam logic [4:0] HOUR_OFF = 5'd24; // midnight, seen as wrap to hour 0

	localparam logic [4:0] START_HOUR   = 5'd19; // preset after reset
	localparam logic [5:0] START_MINUTE = 6'd20;

	// schedule boundaries within the hour
	localparam logic [5:0] SHOW_END_MIN      = 6'd3;
	localparam logic [5:0] PATTERN_START_MIN = 6'd20;
	localparam logic [5:0] PATTERN_END_MIN   = 6'd45;

	localparam int SETTLE_SECONDS = 2; // idle wait before a mode is taken
	localparam int PATTERN_STEPS  = 8; // frames per pattern run

	//////////////////////////////
	// shared types
	//////////////////////////////

	// one bit per channel, bit 0 drives the corner lights
	typedef logic [NUM_LIGHTS-1:0] lights_t;

	typedef enum logic [2:0] {
		PAT_DARK,
		PAT_CHASE,
		PAT_ALTERNATE,
		PAT_FILL,
		PAT_STEADY
	} pattern_e;

	// wall time, 24 hour
	typedef struct packed {
		logic [4:0] hour;
		logic [5:0] minute;
		logic [5:0] second;
	} tod_t;

	// request from sequencer to pattern engine
	typedef struct packed {
		logic     go;
		pattern_e pattern;
	} show_req_t;

endpackage

// ==== pattern/pattern_engine.sv ====
module pattern_engine (
	input  logic                      clk,
	input  logic                      rst_n,
	input  light_show_pkg::show_req_t req,
	input  logic                      step_tick,
	output logic                      finished,
	output light_show_pkg::lights_t   relay,
	output light_show_pkg::lights_t   led
);

	import light_show_pkg::*;

	localparam int STEP_W = $clog2(PATTERN_STEPS);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(PATTERN_STEPS - 1);

	logic [STEP_W-1:0] step_idx;
	logic [STEP_W-1:0] cur_step;
	pattern_e last_pat;
	logic restart;
	lights_t frame;

	// new request or a pattern swap starts over at frame 0
	assign restart  = req.go && (req.pattern != last_pat);
	assign cur_step = restart ? '0 : step_idx;

	//////////////////////////////
	// step counter
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step_idx <= '0;
			last_pat <= PAT_DARK;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (!req.go) begin
				step_idx <= '0;
				last_pat <= PAT_DARK; // so the next go counts as new
			end else if (restart) begin
				step_idx <= '0;
				last_pat <= req.pattern;
			end else if (step_tick) begin
				if (step_idx == LAST_STEP) begin
					step_idx <= '0; // loop while go holds
					finished <= 1'b1;
				end else begin
					step_idx <= step_idx + 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// frame builder
	//////////////////////////////

	always_comb begin
		frame = '0;
		if (req.go) begin
			case (req.pattern)
				PAT_CHASE: begin
					for (int i = 0; i < NUM_LIGHTS; i++)
						frame[i] = (i == int'(cur_step)); // single lit channel
				end
				PAT_ALTERNATE: begin
					frame = cur_step[0] ? lights_t'(8'hAA) : lights_t'(8'h55);
				end
				PAT_FILL: begin
					for (int i = 0; i < NUM_LIGHTS; i++)
						frame[i] = (i <= int'(cur_step)); // grows from the corners
				end
				PAT_STEADY: frame = '1;
				default:    frame = '0;
			endcase
		end
	end

	// ssr inputs are active low, leds follow the frame directly
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led   <= '0;
			relay <= '1;
		end else begin
			led   <= frame;
			relay <= ~frame;
		end
	end

	// a run only ends under a live request
	a_finished_go: assert property (@(posedge clk) disable iff (!rst_n)
		finished |-> req.go);

	a_relay_inverse: assert property (@(posedge clk) disable iff (!rst_n)
		relay == ~led);

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the light show testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f sources.f \
	--top-module light_show_tb \
	-o light_show_sim

./obj_dir/light_show_sim

// ==== sequencer/show_sequencer.sv ====
module show_sequencer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  light_show_pkg::tod_t      tod,
	input  logic [2:0]                dip,
	input  logic                      sec_tick,
	input  logic                      finished,
	output light_show_pkg::show_req_t req
);

	import light_show_pkg::*;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_OFF,
		SEQ_DECIDE,
		SEQ_PLAY,
		SEQ_SHOW
	} seq_state_e;

	localparam int SETTLE_W = $clog2(SETTLE_SECONDS + 1);
	localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(SETTLE_SECONDS - 1);

	seq_state_e state, state_nx;
	show_req_t req_q, req_nx;
	logic sched, sched_nx; // current play came from the schedule
	logic [SETTLE_W-1:0] settle_cnt, settle_nx;
	logic lit;

	// fixed modes from the dip switch, 4 to 7 all steady
	function automatic pattern_e dip_pattern(input logic [2:0] sel);
		case (sel)
			3'd0:    return PAT_DARK;
			3'd1:    return PAT_CHASE;
			3'd2:    return PAT_ALTERNATE;
			3'd3:    return PAT_FILL;
			default: return PAT_STEADY;
		endcase
	endfunction

	// schedule by minute of the hour, chase opens the show
	function automatic pattern_e sched_pattern(input logic [5:0] minute);
		if (minute >= PATTERN_END_MIN)
			return PAT_STEADY;
		else if (minute >= PATTERN_START_MIN)
			return PAT_ALTERNATE;
		else if (minute >= SHOW_END_MIN)
			return PAT_STEADY;
		else
			return PAT_CHASE;
	endfunction

	assign lit = (tod.hour >= HOUR_ON) && (tod.hour < HOUR_OFF);
	assign req = req_q;

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb begin
		state_nx  = state;
		req_nx    = req_q;
		sched_nx  = sched;
		settle_nx = '0;
		case (state)
			SEQ_IDLE: begin
				req_nx.go      = 1'b0; // dark while settling
				req_nx.pattern = PAT_DARK;
				if (!lit) begin
					state_nx = SEQ_OFF;
				end else if (sec_tick && settle_cnt == SETTLE_LAST) begin
					if (dip == 3'd0) begin
						state_nx = SEQ_DECIDE;
					end else begin
						state_nx       = SEQ_PLAY;
						req_nx.go      = 1'b1;
						req_nx.pattern = dip_pattern(dip);
						sched_nx       = 1'b0;
					end
				end else if (sec_tick) begin
					settle_nx = settle_cnt + 1'b1;
				end else begin
					settle_nx = settle_cnt;
				end
			end
			SEQ_DECIDE: begin
				sched_nx = 1'b1;
				if (!lit) begin
					state_nx       = SEQ_OFF;
					req_nx.go      = 1'b0;
					req_nx.pattern = PAT_DARK;
				end else begin
					req_nx.go      = 1'b1;
					req_nx.pattern = sched_pattern(tod.minute);
					state_nx = (tod.minute < SHOW_END_MIN) ? SEQ_SHOW : SEQ_PLAY;
				end
			end
			SEQ_PLAY: begin
				if (finished) begin
					if (!lit) begin
						state_nx       = SEQ_OFF;
						req_nx.go      = 1'b0;
						req_nx.pattern = PAT_DARK;
					end else if (dip == 3'd0) begin
						state_nx = SEQ_DECIDE; // re-read the schedule
					end else if (sched || dip_pattern(dip) != req_q.pattern) begin
						state_nx       = SEQ_IDLE;
						req_nx.go      = 1'b0;
						req_nx.pattern = PAT_DARK;
					end
				end
			end
			SEQ_SHOW: begin
				if (finished) begin
					if (!lit || dip != 3'd0) begin
						state_nx       = lit ? SEQ_IDLE : SEQ_OFF;
						req_nx.go      = 1'b0;
						req_nx.pattern = PAT_DARK;
					end else begin
						case (req_q.pattern)
							PAT_CHASE:     req_nx.pattern = PAT_ALTERNATE;
							PAT_ALTERNATE: req_nx.pattern = PAT_FILL;
							default:       state_nx = SEQ_DECIDE; // show done
						endcase
					end
				end
			end
			SEQ_OFF: begin
				req_nx.go      = 1'b0;
				req_nx.pattern = PAT_DARK;
				if (tod.hour == HOUR_ON)
					state_nx = SEQ_IDLE;
			end
			default: state_nx = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state          <= SEQ_IDLE;
			req_q.go       <= 1'b0;
			req_q.pattern  <= PAT_DARK;
			sched          <= 1'b0;
			settle_cnt     <= '0;
		end else begin
			state      <= state_nx;
			req_q      <= req_nx;
			sched      <= sched_nx;
			settle_cnt <= settle_nx;
		end
	end

	a_off_dark: assert property (@(posedge clk) disable iff (!rst_n)
		(state == SEQ_OFF) |-> !req.go);

endmodule

// ==== sources.f ====
common/light_show_pkg.sv
src/tick_gen.sv
clock/time_of_day.sv
sequencer/show_sequencer.sv
pattern/pattern_engine.sv
src/light_show_top.sv
test/light_show_tb.sv

// ==== src/light_show_top.sv ====
module light_show_top #(
	parameter int CLKS_PER_SECOND = 50_000_000,
	parameter int CLKS_PER_STEP   = 12_500_000
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [2:0]              dip,
	output light_show_pkg::lights_t relay,
	output light_show_pkg::lights_t led
);

	import light_show_pkg::*;

	logic      sec_tick;
	logic      step_tick;
	tod_t      tod;
	show_req_t req;
	logic      finished;

	//////////////////////////////
	// timebase and wall clock
	//////////////////////////////

	tick_gen #(
		.CLKS_PER_SECOND (CLKS_PER_SECOND),
		.CLKS_PER_STEP   (CLKS_PER_STEP)
	) tick_gen_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.sec_tick  (sec_tick),
		.step_tick (step_tick)
	);

	time_of_day time_of_day_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.sec_tick (sec_tick),
		.tod      (tod)
	);

	//////////////////////////////
	// mode control and light drive
	//////////////////////////////

	show_sequencer show_sequencer_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.tod      (tod),
		.dip      (dip),
		.sec_tick (sec_tick),
		.finished (finished),
		.req      (req)
	);

	pattern_engine pattern_engine_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.step_tick (step_tick),
		.finished  (finished),
		.relay     (relay),
		.led       (led)
	);

endmodule

// ==== src/tick_gen.sv ====
module tick_gen #(
	parameter int CLKS_PER_SECOND = 50_000_000,
	parameter int CLKS_PER_STEP   = 12_500_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic sec_tick,
	output logic step_tick
);

	localparam int SEC_W  = $clog2(CLKS_PER_SECOND + 1);
	localparam int STEP_W = $clog2(CLKS_PER_STEP + 1);

	logic [SEC_W-1:0]  sec_cnt;
	logic [STEP_W-1:0] step_cnt;

	// one pulse per second, reload on the last count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_cnt  <= '0;
			sec_tick <= 1'b0;
		end else if (sec_cnt == SEC_W'(CLKS_PER_SECOND - 1)) begin
			sec_cnt  <= '0;
			sec_tick <= 1'b1;
		end else begin
			sec_cnt  <= sec_cnt + 1'b1;
			sec_tick <= 1'b0;
		end
	end

	// frame rate for the pattern engine
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step_cnt  <= '0;
			step_tick <= 1'b0;
		end else if (step_cnt == STEP_W'(CLKS_PER_STEP - 1)) begin
			step_cnt  <= '0;
			step_tick <= 1'b1;
		end else begin
			step_cnt  <= step_cnt + 1'b1;
			step_tick <= 1'b0;
		end
	end

	a_sec_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		(CLKS_PER_SECOND > 1) && sec_tick |=> !sec_tick);
	a_step_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		(CLKS_PER_STEP > 1) && step_tick |=> !step_tick);

endmodule

// ==== test/light_show_tb.sv ====
module light_show_tb;

	import light_show_pkg::*;

	localparam int CLK_PERIOD     = 100;
	localparam int CPS            = 4; // clocks per second tick
	localparam int CPSTEP         = 2; // clocks per frame step
	localparam int RESET_CYCLES   = 5;
	localparam int SETTLE_CYCLES  = SETTLE_SECONDS * CPS;
	localparam int FIRST_TIMEOUT  = 8;
	localparam int NUM_ROWS       = 7;
	// cycles from reset release until the wall clock reaches minute 45
	localparam int SWITCH_CYCLE   = (int'(PATTERN_END_MIN) - int'(START_MINUTE)) * 60 * CPS;
	// cycles from reset release until the wrap to hour 0
	localparam int MIDNIGHT_CYCLE = (int'(HOUR_OFF) * 3600 - int'(START_HOUR) * 3600
		- int'(START_MINUTE) * 60) * CPS;

	typedef enum int {
		CLS_STEADY,
		CLS_CHASE,
		CLS_ALTERNATE,
		CLS_FILL,
		CLS_SCHEDULE,
		CLS_MIDNIGHT
	} class_e;

	logic       clk;
	logic       rst_n;
	logic [2:0] dip;
	lights_t    relay;
	lights_t    led;

	// stimulus table
	string      row_name[NUM_ROWS];
	logic [2:0] row_dip[NUM_ROWS];
	int         row_secs[NUM_ROWS];
	class_e     row_class[NUM_ROWS];
	int         row_timeout[NUM_ROWS];

	integer     seed;
	int         cycle_cnt; // cycles since reset release
	lights_t    prev_led;
	lights_t    frames[$]; // distinct led frames of the row
	string      cur_name;
	class_e     cur_class;

	light_show_top #(
		.CLKS_PER_SECOND (CPS),
		.CLKS_PER_STEP   (CPSTEP)
	) light_show_top_i (
		.clk   (clk),
		.rst_n (rst_n),
		.dip   (dip),
		.relay (relay),
		.led   (led)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// reporting
	//////////////////////////////

	task automatic fail_value(input string what, input lights_t exp, input lights_t act);
		$display("** Error %s: %s expected 0x%02h, got 0x%02h", cur_name, what, exp, act);
		$display("Testbench failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic fail_plain(input string what);
		$display("%s in %s", what, cur_name);
		$display("Testbench failed");
		$fatal(1, "stopped at first failure");
	endtask

	//////////////////////////////
	// frame rules and monitor
	//////////////////////////////

	// the frame that must follow prev, zero prev means first frame
	function automatic lights_t expected_next(input class_e cls, input lights_t prev);
		lights_t exp;
		case (cls)
			CLS_CHASE:     exp = (prev == '0) ? 8'h01 : {prev[6:0], prev[7]};
			CLS_ALTERNATE: exp = (prev == 8'h55) ? 8'hAA : 8'h55;
			CLS_FILL:      exp = (prev == '0 || prev == 8'hFF) ? 8'h01 : {prev[6:0], 1'b1};
			default:       exp = 8'hFF;
		endcase
		return exp;
	endfunction

	task automatic sample_cycle();
		lights_t exp;
		@(negedge clk);
		cycle_cnt++;
		assert (relay == ~led) else fail_value("relay vs inverted led", ~led, relay);
		if (led != prev_led) begin
			frames.push_back(led);
			if (cur_class inside {CLS_STEADY, CLS_CHASE, CLS_ALTERNATE, CLS_FILL}) begin
				exp = expected_next(cur_class, prev_led);
				assert (led == exp) else fail_value("next frame", exp, led);
			end
			prev_led = led;
		end
	endtask

	// waits until led matches (or leaves) target
	task automatic wait_for_led(input lights_t target, input bit match, input int limit,
			input string what);
		int n;
		n = 0;
		while ((led == target) != match) begin
			if (n == limit) begin
				fail_plain({"timeout waiting for ", what});
			end else begin
				sample_cycle();
				n++;
			end
		end
	endtask

	task automatic hold_level(input lights_t level, input int end_cycle, input string what);
		while (cycle_cnt < end_cycle) begin
			sample_cycle();
			assert (led == level) else fail_value(what, level, led);
		end
	endtask

	//////////////////////////////
	// row sequence
	//////////////////////////////

	task automatic apply_reset();
		rst_n = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			dip = 3'($random(seed)); // switch bounce
			assert (led == '0) else fail_value("led in reset", '0, led);
			assert (relay == '1) else fail_value("relay in reset", '1, relay);
		end
		rst_n     = 1'b1;
		cycle_cnt = 0;
		prev_led  = '0;
		frames.delete();
	endtask

	task automatic check_settle(input logic [2:0] dip_val);
		for (int i = 0; i < SETTLE_CYCLES; i++) begin
			sample_cycle();
			if (i < CPS)
				dip = 3'($random(seed));
			else
				dip = dip_val; // settled before the decision tick
			assert (led == '0) else fail_value("led during settle", '0, led);
		end
	endtask

	task automatic run_row(input int r);
		int end_cycle;
		cur_name  = row_name[r];
		cur_class = row_class[r];
		end_cycle = row_secs[r] * CPS;
		apply_reset();
		check_settle(row_dip[r]);
		case (cur_class)
			CLS_SCHEDULE: begin
				cur_class = CLS_ALTERNATE; // 19:20 lies in the alternate window
				wait_for_led('0, 1'b0, FIRST_TIMEOUT, "the first scheduled frame");
				while (cycle_cnt < SWITCH_CYCLE)
					sample_cycle();
				assert (frames.size() > PATTERN_STEPS)
					else fail_plain("too few scheduled alternate frames");
				cur_class = CLS_SCHEDULE; // steady takes over at a run end
				wait_for_led('1, 1'b1, row_timeout[r], "steady after minute 45");
				hold_level('1, end_cycle, "steady after minute 45");
			end
			CLS_MIDNIGHT: begin
				while (cycle_cnt < MIDNIGHT_CYCLE)
					sample_cycle();
				assert (led == '1) else fail_value("steady just before midnight", '1, led);
				wait_for_led('0, 1'b1, row_timeout[r], "dark after midnight");
				hold_level('0, end_cycle, "dark after midnight");
			end
			default: begin
				wait_for_led('0, 1'b0, row_timeout[r], "the first frame");
				while (cycle_cnt < end_cycle)
					sample_cycle();
				if (cur_class == CLS_STEADY) begin
					assert (led == '1) else fail_value("steady at row end", '1, led);
				end else begin
					assert (frames.size() > PATTERN_STEPS)
						else fail_plain("too few distinct frames");
				end
			end
		endcase
		$display("row %s done after %0d cycles", cur_name, cycle_cnt);
	endtask

	task automatic set_row(input int r, input string name, input logic [2:0] d,
			input int secs, input class_e cls, input int tmo);
		row_name[r]    = name;
		row_dip[r]     = d;
		row_secs[r]    = secs;
		row_class[r]   = cls;
		row_timeout[r] = tmo;
	endtask

	task automatic load_table();
		logic [31:0] r;
		r = $random(seed);
		set_row(0, "steady_dip7", 3'd7, 12, CLS_STEADY, 8);
		set_row(1, "steady_dip_rand", 3'd4 + 3'(r % 32'd3), 12, CLS_STEADY, 8);
		set_row(2, "chase", 3'd1, 20, CLS_CHASE, 8);
		set_row(3, "alternate", 3'd2, 20, CLS_ALTERNATE, 8);
		set_row(4, "fill", 3'd3, 20, CLS_FILL, 8);
		set_row(5, "schedule_from_19_20", 3'd0, 1520, CLS_SCHEDULE, 32);
		set_row(6, "past_midnight", 3'd0, 16820, CLS_MIDNIGHT, 32);
	endtask

	initial begin
		seed      = 32'h5fcd_ee00;
		rst_n     = 1'b0;
		dip       = 3'd0;
		cycle_cnt = 0;
		prev_led  = '0;
		cur_name  = "startup";
		cur_class = CLS_STEADY;
		load_table();
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("Testbench passed");
		$finish;
	end

endmodule
